//--- hw/lpif_consts.svh
/*
  Field and link widths for the LPIF link layer.
  LINK_W must equal the sum of the beat fields, and a PHY channel carries PHY_W-2 link bits.
*/
`ifndef LPIF_CONSTS_SVH
`define LPIF_CONSTS_SVH

// Beat fields
`define LPIF_STATE_W   4
`define LPIF_PROTID_W  2
`define LPIF_DATA_W    128
`define LPIF_CRC_W     16

// Flattened beat of state, protid, data, dvalid, crc, crc_valid and valid
`define LINK_W         153

// One die-to-die channel word, strobe and marker included
`define PHY_W          80

// Programmable delay and period counts
`define DELAY_W        16

`endif

//--- hw/lpif_pkg.sv
/*
  Types shared by the link layer. Field order in lpif_beat_t sets the link word layout,
  so changing it breaks the PHY striping on both dies.
*/
`include "lpif_consts.svh"

package lpif_pkg;

  //////////////////////////////////////////////////////////////////////
  // Field vectors

  typedef logic [`LPIF_STATE_W-1:0]  lpif_state_t;
  typedef logic [`LPIF_PROTID_W-1:0] lpif_protid_t;
  typedef logic [`LPIF_DATA_W-1:0]   lpif_data_t;
  typedef logic [`LPIF_CRC_W-1:0]    lpif_crc_t;

  // Flattened beat and one channel word
  typedef logic [`LINK_W-1:0]        link_word_t;
  typedef logic [`PHY_W-1:0]         phy_word_t;

  // Cycle counts for the online delays and the strobe period
  typedef logic [`DELAY_W-1:0]       delay_t;

  //////////////////////////////////////////////////////////////////////
  // LPIF beat, MSB first
  // A plain cast to link_word_t flattens it
  typedef struct packed {
    lpif_state_t  state;
    lpif_protid_t protid;
    lpif_data_t   data;
    logic         dvalid;
    lpif_crc_t    crc;
    logic         crc_valid;
    logic         valid;
  } lpif_beat_t;

  // Online delay counter states
  typedef enum logic [1:0] {
    SYNC_IDLE     = 2'd0,
    SYNC_COUNTING = 2'd1,
    SYNC_ONLINE   = 2'd2
  } sync_state_e;

endpackage

//--- hw/ll_auto_sync.sv
/*
  Delays tx/rx online by programmable edge counts and makes the strobe and marker user bits.
  A delay_z_value of zero turns the strobe off. Delays are sampled live, keep them static.
*/
`timescale 1ns/1ps

module ll_auto_sync import lpif_pkg::*; (
  input  logic   clk_wr,
  input  logic   arst_n,

  // Online requests
  input  logic   tx_online,
  input  logic   rx_online,

  // User bit enables
  input  logic   tx_mrk_userbit,
  input  logic   tx_stb_userbit,

  // Configuration
  input  delay_t delay_x_value,
  input  delay_t delay_y_value,
  input  delay_t delay_z_value,

  output logic   tx_online_delay,
  output logic   rx_online_delay,
  output logic   auto_stb,
  output logic   auto_mrk
);

  //////////////////////////////////////////////////////////////////////
  // Online delay counters

  // Lane 0 is transmit, lane 1 is receive
  logic [1:0] online_in;
  logic [1:0] online_dly;
  delay_t     online_cnt_max [2];

  delay_t     stb_cnt;
  logic       stb_q;

  assign online_in         = {rx_online, tx_online};
  assign online_cnt_max[0] = delay_y_value;
  assign online_cnt_max[1] = delay_x_value;

  for (genvar i = 0; i < 2; i++) begin : g_online
    sync_state_e st;
    // Edges seen since the first high sample
    delay_t      cnt;

    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        st  <= SYNC_IDLE;
        cnt <= '0;
      end else if (!online_in[i]) begin
        // Low sample drops straight back
        st  <= SYNC_IDLE;
        cnt <= '0;
      end else begin
        case (st)
          SYNC_IDLE: begin
            // Zero delay goes online on the first high edge
            if (online_cnt_max[i] == '0) begin
              st <= SYNC_ONLINE;
            end else begin
              st  <= SYNC_COUNTING;
              cnt <= delay_t'(1);
            end
          end
          SYNC_COUNTING: begin
            if (cnt >= online_cnt_max[i]) begin
              st <= SYNC_ONLINE;
            end else begin
              cnt <= cnt + delay_t'(1);
            end
          end
          SYNC_ONLINE: st <= SYNC_ONLINE;
          default:     st <= SYNC_IDLE;
        endcase
      end
    end

    assign online_dly[i] = (st == SYNC_ONLINE);
  end

  assign tx_online_delay = online_dly[0];
  assign rx_online_delay = online_dly[1];

  //////////////////////////////////////////////////////////////////////
  // Persistent strobe

  // Period counter restarts whenever tx goes offline
  // Pulse lands on the first high edge, then every delay_z_value edges
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_cnt <= '0;
      stb_q   <= 1'b0;
    end else if (!tx_online) begin
      stb_cnt <= '0;
      stb_q   <= 1'b0;
    end else begin
      stb_q <= tx_stb_userbit && (delay_z_value != '0) && (stb_cnt == '0);
      // Wrap at period - 1
      if (stb_cnt >= delay_z_value - delay_t'(1)) begin
        stb_cnt <= '0;
      end else begin
        stb_cnt <= stb_cnt + delay_t'(1);
      end
    end
  end

  assign auto_stb = stb_q;

  // Marker only once tx is online
  assign auto_mrk = tx_mrk_userbit & tx_online_delay;

endmodule

//--- hw/lpif_link_packer.sv
/*
  Registers ustrm into the link word and the received link word into dstrm in one cycle each.
  dstrm valid flags are forced low while rx is not online; payload fields are not gated.
*/
`timescale 1ns/1ps

module lpif_link_packer import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       arst_n,

  // From the sync block
  input  logic       rx_online_delay,

  // Upstream beat and received link word
  input  lpif_beat_t ustrm,
  input  link_word_t rx_link,

  output link_word_t tx_link,
  output lpif_beat_t dstrm
);

  //////////////////////////////////////////////////////////////////////
  // Transmit

  // Flatten by cast so field order follows the struct
  always_ff @(posedge clk_wr) begin
    tx_link <= link_word_t'(ustrm);
  end

  //////////////////////////////////////////////////////////////////////
  // Receive

  lpif_beat_t rx_beat;

  assign rx_beat = lpif_beat_t'(rx_link);

  // Flags gated so misaligned PHY content never looks valid
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      dstrm <= '0;
    end else begin
      dstrm <= rx_beat;
      if (!rx_online_delay) begin
        dstrm.valid     <= 1'b0;
        dstrm.dvalid    <= 1'b0;
        dstrm.crc_valid <= 1'b0;
      end
    end
  end

endmodule

//--- hw/lpif_phy_concat.sv
/*
  Full rate only. The link word is striped over two channels every cycle, no gen1 mode.
  tx_phy is all zero until tx_online_delay is high. rx side trusts word alignment.
*/
`timescale 1ns/1ps
`include "lpif_consts.svh"

module lpif_phy_concat import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       arst_n,

  // From the sync block
  input  logic       tx_online_delay,
  input  logic       auto_stb,
  input  logic       auto_mrk,

  // Link side
  input  link_word_t tx_link,
  output link_word_t rx_link,

  // PHY side
  output phy_word_t  tx_phy0,
  output phy_word_t  tx_phy1,
  input  phy_word_t  rx_phy0,
  input  phy_word_t  rx_phy1
);

  //////////////////////////////////////////////////////////////////////
  // Channel layout

  // Link bits per channel with the strobe in the middle and the marker on top
  localparam int CH_BITS = `PHY_W - 2;
  localparam int HALF    = CH_BITS / 2;
  localparam int PAD_W   = 2 * CH_BITS;

  // Insert strobe at bit HALF and marker at the MSB
  function automatic phy_word_t stripe(
    input logic [CH_BITS-1:0] bits,
    input logic               stb,
    input logic               mrk
  );
    stripe = {mrk, bits[CH_BITS-1:HALF], stb, bits[HALF-1:0]};
  endfunction

  // Drop strobe and marker, keep the link bits
  function automatic logic [CH_BITS-1:0] gather(input phy_word_t word);
    gather = {word[`PHY_W-2:HALF+1], word[HALF-1:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Transmit

  logic [PAD_W-1:0] tx_pad;
  logic [PAD_W-1:0] rx_pad;

  // Spare bits on top of channel 1 go out as zero
  assign tx_pad = {{(PAD_W - `LINK_W){1'b0}}, tx_link};

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else if (!tx_online_delay) begin
      // Quiet line until online
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      // Channel 0 takes the low link bits and channel 1 the rest
      tx_phy0 <= stripe(tx_pad[CH_BITS-1:0], auto_stb, auto_mrk);
      tx_phy1 <= stripe(tx_pad[PAD_W-1:CH_BITS], auto_stb, auto_mrk);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive

  // Strobe, marker and the spare bits fall away here
  assign rx_pad = {gather(rx_phy1), gather(rx_phy0)};

  always_ff @(posedge clk_wr) begin
    rx_link <= rx_pad[`LINK_W-1:0];
  end

endmodule

//--- hw/lpif_slave_top.sv
/*
  Link layer slave, one LPIF beat per clock over two PHY channels. Single clock, clk_wr.
  No handshake or back-pressure; ustrm to dstrm is 4 cycles through an external loopback.
*/
`timescale 1ns/1ps

module lpif_slave_top import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       arst_n,

  // Control
  input  logic       tx_online,
  input  logic       rx_online,

  // Configuration
  input  delay_t     delay_x_value,
  input  delay_t     delay_y_value,
  input  delay_t     delay_z_value,
  input  logic       tx_mrk_userbit,
  input  logic       tx_stb_userbit,

  // LPIF beats
  input  lpif_beat_t ustrm,
  output lpif_beat_t dstrm,

  // PHY interconnect
  output phy_word_t  tx_phy0,
  output phy_word_t  tx_phy1,
  input  phy_word_t  rx_phy0,
  input  phy_word_t  rx_phy1
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect

  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       auto_stb;
  logic       auto_mrk;
  link_word_t tx_link;
  link_word_t rx_link;

  // Online delays, strobe and marker
  ll_auto_sync u_sync (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .auto_stb        (auto_stb),
    .auto_mrk        (auto_mrk)
  );

  // Beat to link word and back
  lpif_link_packer u_packer (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .rx_online_delay (rx_online_delay),
    .ustrm           (ustrm),
    .rx_link         (rx_link),
    .tx_link         (tx_link),
    .dstrm           (dstrm)
  );

  // Link word on and off the two channels
  lpif_phy_concat u_concat (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online_delay (tx_online_delay),
    .auto_stb        (auto_stb),
    .auto_mrk        (auto_mrk),
    .tx_link         (tx_link),
    .rx_link         (rx_link),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1)
  );

endmodule

//--- tb/lpif_checker.sv
/*
  Reference model of the slave with tx_phy looped to rx_phy and sampled on the falling edge.
  Full dstrm is compared only for beats flagged expect; flags and tx_phy every cycle.
*/
`timescale 1ns/1ps
`include "lpif_consts.svh"

module lpif_checker import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       arst_n,
  input  logic       tx_online,
  input  logic       rx_online,
  input  logic       tx_mrk_userbit,
  input  logic       tx_stb_userbit,
  input  delay_t     delay_y_value,
  input  delay_t     delay_x_value,
  input  delay_t     delay_z_value,
  input  lpif_beat_t ustrm,
  input  logic       expect_beat,
  input  lpif_beat_t dstrm,
  input  phy_word_t  tx_phy0,
  input  phy_word_t  tx_phy1,
  output int         phy_errors,
  output int         dstrm_errors,
  output int         beats_checked
);

  localparam int CH_BITS = `PHY_W - 2;

  // Channel word from link bits with the strobe at 39 and the marker at 79
  function automatic phy_word_t build_phy(link_word_t lw, int ch, logic stb, logic mrk);
    phy_word_t w;
    int        b;
    w = '0;
    for (int j = 0; j < CH_BITS; j++) begin
      b = ch * CH_BITS + j;
      if (b < `LINK_W) begin
        if (j < CH_BITS / 2) w[j] = lw[b];
        else w[j + 1] = lw[b];
      end
    end
    w[CH_BITS / 2] = stb;
    w[`PHY_W - 1]  = mrk;
    return w;
  endfunction

  // Link word back from both channels
  function automatic link_word_t gather_link(phy_word_t w0, phy_word_t w1);
    link_word_t lw;
    phy_word_t  w;
    int         b;
    lw = '0;
    for (int ch = 0; ch < 2; ch++) begin
      w = (ch == 0) ? w0 : w1;
      for (int j = 0; j < CH_BITS; j++) begin
        b = ch * CH_BITS + j;
        if (b < `LINK_W) lw[b] = (j < CH_BITS / 2) ? w[j] : w[j + 1];
      end
    end
    return lw;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // One copy of each DUT register stage

  int         phy_err = 0;
  int         dstrm_err = 0;
  int         checked = 0;
  logic       have_q = 1'b0;
  // Inputs seen at the previous falling edge and sampled by the next rising edge
  logic       tx_q, rx_q, mrk_q, stb_en_q, exp_q;
  delay_t     dx_q, dy_q, dz_q;
  lpif_beat_t ustrm_q;
  // Pipeline stages
  link_word_t link_m, rxl_m;
  phy_word_t  phy0_m, phy1_m;
  lpif_beat_t dbeat_m;
  logic       e_link, e_phy, e_rxl, e_d;
  // Sync model
  int         tx_hi, rx_hi, hcnt;
  logic       txd_m, rxd_m, stb_m;

  assign phy_errors    = phy_err;
  assign dstrm_errors  = dstrm_err;
  assign beats_checked = checked;

  always @(negedge clk_wr) begin
    if (!arst_n) begin
      have_q  = 1'b0;
      link_m  = '0;
      rxl_m   = '0;
      phy0_m  = '0;
      phy1_m  = '0;
      dbeat_m = '0;
      {e_link, e_phy, e_rxl, e_d} = '0;
      {txd_m, rxd_m, stb_m} = '0;
      tx_hi = 0;
      rx_hi = 0;
      hcnt  = 0;
    end else begin
      if (have_q) begin
        // Stages updated back to front so each uses the old value
        dbeat_m = lpif_beat_t'(rxl_m);
        if (!rxd_m) begin
          dbeat_m.valid     = 1'b0;
          dbeat_m.dvalid    = 1'b0;
          dbeat_m.crc_valid = 1'b0;
        end
        rxl_m = gather_link(phy0_m, phy1_m);
        phy0_m = txd_m ? build_phy(link_m, 0, stb_m, mrk_q) : '0;
        phy1_m = txd_m ? build_phy(link_m, 1, stb_m, mrk_q) : '0;
        link_m = link_word_t'(ustrm_q);
        e_d    = e_rxl;
        e_rxl  = e_phy;
        e_phy  = e_link;
        e_link = exp_q;

        // Online delays go high once the edge count minus one reaches the delay
        tx_hi = tx_q ? ((tx_hi < 65536) ? tx_hi + 1 : tx_hi) : 0;
        rx_hi = rx_q ? ((rx_hi < 65536) ? rx_hi + 1 : rx_hi) : 0;
        txd_m = tx_q && (tx_hi - 1 >= int'(dy_q));
        rxd_m = rx_q && (rx_hi - 1 >= int'(dx_q));
        // Strobe on the first high edge and every dz high edges after it
        if (!tx_q) begin
          stb_m = 1'b0;
          hcnt  = 0;
        end else begin
          stb_m = stb_en_q && (dz_q != '0) && ((hcnt % int'(dz_q)) == 0);
          hcnt  = hcnt + 1;
        end
      end

      // Snapshot for the next rising edge
      tx_q     = tx_online;
      rx_q     = rx_online;
      mrk_q    = tx_mrk_userbit;
      stb_en_q = tx_stb_userbit;
      dx_q     = delay_x_value;
      dy_q     = delay_y_value;
      dz_q     = delay_z_value;
      ustrm_q  = ustrm;
      exp_q    = expect_beat;
      have_q   = 1'b1;
    end

    // Model is all zero in reset, so reset values are covered here too
    if (tx_phy0 !== phy0_m) begin
      $display("ERROR %0t tx_phy0 expected %h actual %h", $time, phy0_m, tx_phy0);
      phy_err++;
    end
    if (tx_phy1 !== phy1_m) begin
      $display("ERROR %0t tx_phy1 expected %h actual %h", $time, phy1_m, tx_phy1);
      phy_err++;
    end
    if ({dstrm.valid, dstrm.dvalid, dstrm.crc_valid} !==
        {dbeat_m.valid, dbeat_m.dvalid, dbeat_m.crc_valid}) begin
      $display("ERROR %0t dstrm.flags expected %b actual %b", $time,
               {dbeat_m.valid, dbeat_m.dvalid, dbeat_m.crc_valid},
               {dstrm.valid, dstrm.dvalid, dstrm.crc_valid});
      dstrm_err++;
    end
    if (e_d) begin
      checked++;
      if (dstrm !== dbeat_m) begin
        $display("ERROR %0t dstrm expected %h actual %h", $time, dbeat_m, dstrm);
        dstrm_err++;
      end
    end
  end

endmodule

//--- tb/tb_lpif_slave.sv
/*
  PHY loopback testbench that reads its rows from tb/lpif_stimulus.txt relative to the root.
  Config rows apply at once. Beat rows take one clock each and are driven 1 ns after the edge.
*/
`timescale 1ns/1ps
`include "lpif_consts.svh"

module tb_lpif_slave import lpif_pkg::*; ();

  typedef struct packed {
    logic       is_cfg;
    logic       tx;
    logic       rx;
    logic       rnd;
    logic       expect_beat;
    lpif_beat_t beat;
    delay_t     dx;
    delay_t     dy;
    delay_t     dz;
    logic       mrk;
    logic       stb;
  } row_t;

  logic       clk_wr;
  logic       arst_n;
  logic       tx_online, rx_online, tx_mrk_userbit, tx_stb_userbit, expect_beat;
  delay_t     delay_x_value, delay_y_value, delay_z_value;
  lpif_beat_t ustrm, dstrm;
  phy_word_t  tx_phy0, tx_phy1;
  int         phy_errors, dstrm_errors, beats_checked;
  row_t       rows[$];
  logic       rows_loaded = 1'b0;
  int         seed = 85756;

  lpif_slave_top dut0 (
    .clk_wr(clk_wr), .arst_n(arst_n),
    .tx_online(tx_online), .rx_online(rx_online),
    .delay_x_value(delay_x_value), .delay_y_value(delay_y_value),
    .delay_z_value(delay_z_value),
    .tx_mrk_userbit(tx_mrk_userbit), .tx_stb_userbit(tx_stb_userbit),
    .ustrm(ustrm), .dstrm(dstrm),
    // Straight loopback
    .tx_phy0(tx_phy0), .tx_phy1(tx_phy1), .rx_phy0(tx_phy0), .rx_phy1(tx_phy1)
  );

  lpif_checker chk0 (
    .clk_wr(clk_wr), .arst_n(arst_n),
    .tx_online(tx_online), .rx_online(rx_online),
    .tx_mrk_userbit(tx_mrk_userbit), .tx_stb_userbit(tx_stb_userbit),
    .delay_y_value(delay_y_value), .delay_x_value(delay_x_value),
    .delay_z_value(delay_z_value),
    .ustrm(ustrm), .expect_beat(expect_beat), .dstrm(dstrm),
    .tx_phy0(tx_phy0), .tx_phy1(tx_phy1),
    .phy_errors(phy_errors), .dstrm_errors(dstrm_errors), .beats_checked(beats_checked)
  );

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  // Rows into the queue with comment lines skipped
  task automatic load_rows();
    int    fd;
    int    kind;
    int    f[10];
    lpif_data_t data;
    string line;
    row_t  r;
    fd = $fopen("tb/lpif_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/lpif_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == 8'h23) continue;
        void'($sscanf(line, "%d", kind));
        r = '0;
        if (kind == 0) begin
          void'($sscanf(line, "%d %d %d %d %d %d", kind, f[0], f[1], f[2], f[3], f[4]));
          r.is_cfg = 1'b1;
          r.dx  = delay_t'(f[0]);
          r.dy  = delay_t'(f[1]);
          r.dz  = delay_t'(f[2]);
          r.mrk = f[3][0];
          r.stb = f[4][0];
        end else begin
          void'($sscanf(line, "%d %d %d %h %h %h %d %d %h %d %d %d", kind, f[0], f[1],
                        f[2], f[3], data, f[4], f[5], f[6], f[7], f[8], f[9]));
          r.tx = f[0][0];
          r.rx = f[1][0];
          r.beat.state     = lpif_state_t'(f[2]);
          r.beat.protid    = lpif_protid_t'(f[3]);
          r.beat.data      = data;
          r.rnd            = f[4][0];
          r.beat.dvalid    = f[5][0];
          r.beat.crc       = lpif_crc_t'(f[6]);
          r.beat.crc_valid = f[7][0];
          r.beat.valid     = f[8][0];
          r.expect_beat    = f[9][0];
        end
        rows.push_back(r);
      end
      $fclose(fd);
    end
  endtask

  // Watchdog sized by the number of stimulus rows
  initial begin
    int limit_ns;
    wait (rows_loaded);
    limit_ns = (rows.size() + 50) * 10;
    #(limit_ns);
    $display("Timeout: simulation did not finish within %0d ns", limit_ns);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    arst_n = 1'b0;
    {tx_online, rx_online, tx_mrk_userbit, tx_stb_userbit, expect_beat} = '0;
    {delay_x_value, delay_y_value, delay_z_value} = '0;
    ustrm = '0;
    load_rows();
    if (rows.size() == 0) begin
      $display("No stimulus rows were loaded, nothing to run");
      $display(">>> FAIL");
      $finish;
    end else begin
      rows_loaded = 1'b1;
      repeat (2) @(posedge clk_wr);
      #1 arst_n = 1'b1;

      foreach (rows[i]) begin
        if (rows[i].is_cfg) begin
          delay_x_value  = rows[i].dx;
          delay_y_value  = rows[i].dy;
          delay_z_value  = rows[i].dz;
          tx_mrk_userbit = rows[i].mrk;
          tx_stb_userbit = rows[i].stb;
        end else begin
          @(posedge clk_wr);
          #1;
          tx_online   = rows[i].tx;
          rx_online   = rows[i].rx;
          expect_beat = rows[i].expect_beat;
          ustrm       = rows[i].beat;
          if (rows[i].rnd) begin
            ustrm.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
          end
        end
      end

      // Drain the pipeline
      @(posedge clk_wr);
      #1;
      {tx_online, rx_online, expect_beat} = '0;
      ustrm = '0;
      repeat (6) @(posedge clk_wr);
      @(negedge clk_wr);
      #1;

      $display("Summary: %0d tx_phy errors, %0d dstrm errors, %0d loopback beats checked",
               phy_errors, dstrm_errors, beats_checked);
      if (beats_checked == 0) begin
        $display("No loopback beat reached the compare stage");
      end
      if (phy_errors == 0 && dstrm_errors == 0 && beats_checked > 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule

//--- sim.f
+incdir+hw
hw/lpif_pkg.sv
hw/ll_auto_sync.sv
hw/lpif_link_packer.sv
hw/lpif_phy_concat.sv
hw/lpif_slave_top.sv
tb/lpif_checker.sv
tb/tb_lpif_slave.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the LPIF slave testbench with Verilator and run it from the project root.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot change to the project root"
  exit 1
fi

verilator --binary --timing -f sim.f --top-module tb_lpif_slave -o sim_lpif
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_lpif)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qxF '>>> PASS'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- tb/lpif_stimulus.txt
# config: 0 delay_x delay_y delay_z tx_mrk_userbit tx_stb_userbit
# beat: 1 tx_online rx_online state protid data(hex) rnd dvalid crc(hex) crc_valid valid expect
0 1 2 3 1 1
1 0 0 0 0 00000000000000000000000000000000 0 0 0000 0 0 0
1 0 0 1 1 11111111111111111111111111111111 0 1 1111 1 1 0
1 1 1 2 2 22222222222222222222222222222222 0 1 2222 1 1 0
1 1 1 3 3 33333333333333333333333333333333 0 1 3333 1 1 0
1 1 1 4 0 44444444444444444444444444444444 0 1 4444 1 1 0
1 1 1 5 1 55555555555555555555555555555555 0 1 5555 1 1 1
1 1 1 6 2 0123456789abcdeffedcba9876543210 0 1 a5a5 1 1 1
1 1 1 7 3 00000000000000000000000000000000 1 1 beef 1 1 1
1 1 1 8 0 00000000000000000000000000000000 1 0 cafe 1 1 1
1 1 1 9 1 00000000000000000000000000000000 1 1 f00d 0 1 1
1 1 1 a 2 00000000000000000000000000000000 1 0 1234 0 1 1
1 1 1 b 3 ffffffffffffffffffffffffffffffff 0 1 ffff 1 0 1
1 1 1 c 0 80000000000000000000000000000001 0 0 8001 1 0 1
1 1 1 d 1 00000000000000000000000000000000 1 1 0f0f 1 1 1
1 1 1 e 2 00000000000000000000000000000000 1 0 0000 0 0 1
1 1 1 f 3 00000000000000000000000000000000 1 1 7777 1 1 1
1 1 0 1 0 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 0 1 aaaa 1 1 1
1 1 0 2 1 55555555555555555555555555555555 0 1 5555 1 1 1
1 1 0 3 2 00000000000000000000000000000000 1 1 3c3c 1 1 1
1 0 0 4 3 00000000000000000000000000000000 1 1 c3c3 1 1 0
1 0 0 0 0 00000000000000000000000000000000 0 0 0000 0 0 0
0 0 0 0 0 1
1 0 0 0 0 00000000000000000000000000000000 0 0 0000 0 0 0
1 1 1 1 1 00000000000000000000000000000000 1 1 1111 1 1 0
1 1 1 2 2 00000000000000000000000000000000 1 1 2222 1 1 1
1 1 1 3 3 00000000000000000000000000000000 1 0 3333 1 1 1
1 1 1 4 0 00000000000000000000000000000000 1 1 4444 0 1 1
1 1 1 5 1 00000000000000000000000000000000 1 1 5555 1 0 1
1 1 1 6 2 00000000000000000000000000000000 1 1 6666 1 1 1
1 1 1 7 3 00000000000000000000000000000000 1 1 7777 1 1 1
1 0 1 8 0 00000000000000000000000000000000 1 1 8888 1 1 1
1 0 0 0 0 00000000000000000000000000000000 0 0 0000 0 0 0
